// ==== rtl/srio_pkg.sv ====
// Shared RapidIO constants and header builders; beat layouts assume 64-bit HELLO-style packets
package srio_pkg;

    localparam int ADDR_W = 34;
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    // FIFO entry holds first, last, keep and data
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int FIFO_ENTRY_W = 2 + KEEP_W + DATA_W;

    localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
    localparam logic [3:0] FTYPE_NWRITE = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE = 4'h4;
    localparam logic [1:0] REQ_PRIO = 2'd1;

    localparam logic [15:0] TARGET_RESP_ID = 16'h00F0;
    localparam logic [15:0] DB_INFO_SELF = 16'h0101;
    localparam logic [15:0] DB_INFO_READY = 16'h0100;
    localparam logic [15:0] DB_INFO_BUSY = 16'h01FF;
    localparam logic [15:0] DB_INFO_INTEG_BASE = 16'h0200;

    // Target window is 1 MiB per window bit
    localparam int WINDOW_STRIDE_SHIFT = 20;

    localparam int TIMEOUT_CYCLES = 65536;
    localparam int TIMER_W = $clog2(TIMEOUT_CYCLES);
    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(TIMEOUT_CYCLES - 1);

    localparam logic [1:0] ERR_NONE = 2'd0;
    localparam logic [1:0] ERR_DB_TIMEOUT = 2'd1;
    localparam logic [1:0] ERR_ACK_TIMEOUT = 2'd2;

    typedef enum logic [2:0] {
        IDLE,
        DB_REQ,
        DB_RESP,
        NWR,
        INTEG_REQ,
        WAIT_ACK
    } seq_state_t;

    function automatic logic [DATA_W-1:0] build_doorbell(
        input logic [7:0] tid,
        input logic [15:0] info
    );
        logic [DATA_W-1:0] beat;
        beat = '0;
        beat[63:56] = tid;
        beat[55:52] = FTYPE_DOORBELL;
        beat[46:45] = REQ_PRIO;
        beat[31:16] = info;
        return beat;
    endfunction

    function automatic logic [DATA_W-1:0] build_nwr_header(
        input logic [7:0] tid,
        input logic [7:0] size,
        input logic [ADDR_W-1:0] addr
    );
        logic [DATA_W-1:0] beat;
        beat = '0;
        beat[63:56] = tid;
        beat[55:52] = FTYPE_NWRITE;
        beat[51:48] = TTYPE_NWRITE;
        beat[46:45] = REQ_PRIO;
        beat[43:36] = size;
        beat[33:0] = addr;
        return beat;
    endfunction

endpackage

// ==== rtl/user_beat_fifo.sv ====
// First-word-fall-through FIFO; pushes while full and pops while empty are ignored
module user_beat_fifo (
    input  logic                       log_clk,
    input  logic                       log_rst,
    input  logic                       push_i,
    input  logic                       push_first_i,
    input  logic                       push_last_i,
    input  logic [srio_pkg::KEEP_W-1:0] push_keep_i,
    input  logic [srio_pkg::DATA_W-1:0] push_data_i,
    input  logic                       pop_i,
    output logic                       full_o,
    output logic                       head_valid_o,
    output logic                       head_first_o,
    output logic                       head_last_o,
    output logic [srio_pkg::KEEP_W-1:0] head_keep_o,
    output logic [srio_pkg::DATA_W-1:0] head_data_o
);

    logic [srio_pkg::FIFO_ENTRY_W-1:0] mem [srio_pkg::FIFO_DEPTH];
    logic [srio_pkg::FIFO_AW-1:0] wr_ptr;
    logic [srio_pkg::FIFO_AW-1:0] rd_ptr;
    logic [srio_pkg::FIFO_AW:0] count;
    logic do_push;
    logic do_pop;

    assign full_o = (count == (srio_pkg::FIFO_AW + 1)'(srio_pkg::FIFO_DEPTH));
    assign head_valid_o = (count != '0);
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && head_valid_o;

    // Head entry is read straight from the array
    assign {head_first_o, head_last_o, head_keep_o, head_data_o} = mem[rd_ptr];

    always_ff @(posedge log_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_first_i, push_last_i, push_keep_i, push_data_i};
        end
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

endmodule

// ==== rtl/resp_decode.sv ====
// Doorbell response classifier; only doorbells from TARGET_RESP_ID count, events lag by one cycle
module resp_decode (
    input  logic                       log_clk,
    input  logic                       log_rst,
    input  logic                       iresp_tvalid_i,
    input  logic [srio_pkg::DATA_W-1:0] iresp_tdata_i,
    input  logic [31:0]                iresp_tuser_i,
    input  logic [15:0]                expect_info_i,
    output logic                       ev_ready_o,
    output logic                       ev_busy_o,
    output logic                       ev_confirm_o
);

    logic        resp_hit;
    logic [15:0] resp_info;

    assign resp_info = iresp_tdata_i[31:16];

    // Source ID sits in the upper half of tuser
    assign resp_hit = iresp_tvalid_i
                   && (iresp_tdata_i[55:52] == srio_pkg::FTYPE_DOORBELL)
                   && (iresp_tuser_i[31:16] == srio_pkg::TARGET_RESP_ID);

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            ev_ready_o <= 1'b0;
            ev_busy_o <= 1'b0;
            ev_confirm_o <= 1'b0;
        end else begin
            ev_ready_o <= resp_hit && (resp_info == srio_pkg::DB_INFO_READY);
            ev_busy_o <= resp_hit && (resp_info == srio_pkg::DB_INFO_BUSY);
            ev_confirm_o <= resp_hit && (resp_info == expect_info_i);
        end
    end

endmodule

// ==== rtl/req_sequencer.sv ====
// Request FSM; assumes each FIFO packet starts with a header entry and ends with tlast
module req_sequencer (
    input  logic                         log_clk,
    input  logic                         log_rst,
    input  logic                         self_check_i,
    input  logic                         nwr_req_i,
    input  logic                         link_initialized_i,
    input  logic [15:0]                  src_id_i,
    input  logic [15:0]                  des_id_i,
    input  logic                         ireq_tready_i,
    input  logic                         head_valid_i,
    input  logic                         head_first_i,
    input  logic                         head_last_i,
    input  logic [srio_pkg::KEEP_W-1:0]  head_keep_i,
    input  logic [srio_pkg::DATA_W-1:0]  head_data_i,
    input  logic                         ev_ready_i,
    input  logic                         ev_busy_i,
    input  logic                         ev_confirm_i,
    output logic                         ireq_tvalid_o,
    output logic [srio_pkg::DATA_W-1:0]  ireq_tdata_o,
    output logic [srio_pkg::KEEP_W-1:0]  ireq_tkeep_o,
    output logic                         ireq_tlast_o,
    output logic [31:0]                  ireq_tuser_o,
    output logic                         fifo_pop_o,
    output logic [15:0]                  expect_info_o,
    output logic                         rapidio_ready_o,
    output logic                         cmd_start_o,
    output logic                         nwr_start_o,
    output logic                         got_ready_o,
    output logic                         got_busy_o,
    output logic                         db_timeout_o,
    output logic                         ack_timeout_o,
    output logic                         ack_done_o
);

    srio_pkg::seq_state_t state;
    logic [srio_pkg::TIMER_W-1:0] timer;
    logic window;
    logic req_fire;
    logic timed_out;
    logic [7:0] tid;
    logic [srio_pkg::ADDR_W-1:0] target_addr;

    // Window bit selects transaction ID, target window and integrity info
    assign tid = {7'd0, window};
    assign target_addr = srio_pkg::ADDR_W'(window) << srio_pkg::WINDOW_STRIDE_SHIFT;
    assign expect_info_o = window ? srio_pkg::DB_INFO_INTEG_BASE
                                  : srio_pkg::DB_INFO_INTEG_BASE + 16'd1;

    assign req_fire = ireq_tvalid_o && ireq_tready_i;
    assign timed_out = (timer == srio_pkg::TIMER_LAST);
    assign rapidio_ready_o = (state == srio_pkg::IDLE);
    assign ireq_tuser_o = {src_id_i, des_id_i};

    // Beat stays stable until accepted since it depends only on state and FIFO head
    always_comb begin
        ireq_tvalid_o = 1'b0;
        ireq_tdata_o = '0;
        ireq_tkeep_o = '1;
        ireq_tlast_o = 1'b0;
        fifo_pop_o = 1'b0;
        case (state)
            srio_pkg::DB_REQ: begin
                ireq_tvalid_o = 1'b1;
                ireq_tdata_o = srio_pkg::build_doorbell(tid, srio_pkg::DB_INFO_SELF);
                ireq_tlast_o = 1'b1;
            end
            srio_pkg::NWR: begin
                ireq_tvalid_o = head_valid_i;
                // Header entry carries the size byte in its low data bits
                if (head_first_i) begin
                    ireq_tdata_o = srio_pkg::build_nwr_header(tid, head_data_i[7:0],
                                                              target_addr);
                end else begin
                    ireq_tdata_o = head_data_i;
                    ireq_tkeep_o = head_keep_i;
                end
                ireq_tlast_o = head_last_i;
                fifo_pop_o = head_valid_i && ireq_tready_i;
            end
            srio_pkg::INTEG_REQ: begin
                ireq_tvalid_o = 1'b1;
                ireq_tdata_o = srio_pkg::build_doorbell(tid, expect_info_o);
                ireq_tlast_o = 1'b1;
            end
            default: begin
                ireq_tvalid_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            state <= srio_pkg::IDLE;
            timer <= '0;
            window <= 1'b0;
            cmd_start_o <= 1'b0;
            nwr_start_o <= 1'b0;
            got_ready_o <= 1'b0;
            got_busy_o <= 1'b0;
            db_timeout_o <= 1'b0;
            ack_timeout_o <= 1'b0;
            ack_done_o <= 1'b0;
        end else begin
            cmd_start_o <= 1'b0;
            nwr_start_o <= 1'b0;
            got_ready_o <= 1'b0;
            got_busy_o <= 1'b0;
            db_timeout_o <= 1'b0;
            ack_timeout_o <= 1'b0;
            ack_done_o <= 1'b0;
            // Timer runs only while waiting for the target
            if (state == srio_pkg::DB_RESP || state == srio_pkg::WAIT_ACK) begin
                timer <= timer + 1'b1;
            end else begin
                timer <= '0;
            end
            case (state)
                srio_pkg::IDLE: begin
                    if (link_initialized_i && self_check_i) begin
                        state <= srio_pkg::DB_REQ;
                        cmd_start_o <= 1'b1;
                    end else if (link_initialized_i && nwr_req_i) begin
                        state <= srio_pkg::NWR;
                        cmd_start_o <= 1'b1;
                        nwr_start_o <= 1'b1;
                    end
                end
                srio_pkg::DB_REQ: begin
                    if (req_fire) begin
                        state <= srio_pkg::DB_RESP;
                    end
                end
                srio_pkg::DB_RESP: begin
                    if (ev_ready_i) begin
                        state <= srio_pkg::IDLE;
                        got_ready_o <= 1'b1;
                    end else if (ev_busy_i) begin
                        state <= srio_pkg::IDLE;
                        got_busy_o <= 1'b1;
                    end else if (timed_out) begin
                        state <= srio_pkg::IDLE;
                        db_timeout_o <= 1'b1;
                    end
                end
                srio_pkg::NWR: begin
                    if (req_fire && ireq_tlast_o) begin
                        state <= srio_pkg::INTEG_REQ;
                    end
                end
                srio_pkg::INTEG_REQ: begin
                    if (req_fire) begin
                        state <= srio_pkg::WAIT_ACK;
                    end
                end
                srio_pkg::WAIT_ACK: begin
                    if (ev_confirm_i) begin
                        state <= srio_pkg::IDLE;
                        window <= ~window;
                        ack_done_o <= 1'b1;
                    end else if (timed_out) begin
                        state <= srio_pkg::IDLE;
                        ack_timeout_o <= 1'b1;
                    end
                end
                default: begin
                    state <= srio_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/status_report.sv ====
// Sticky status for the user; busy and error hold until the next command starts
module status_report (
    input  logic        log_clk,
    input  logic        log_rst,
    input  logic [15:0] des_id_i,
    input  logic        cmd_start_i,
    input  logic        nwr_start_i,
    input  logic        got_ready_i,
    input  logic        got_busy_i,
    input  logic        db_timeout_i,
    input  logic        ack_timeout_i,
    input  logic        ack_done_i,
    output logic        nwr_ready_o,
    output logic        nwr_busy_o,
    output logic        nwr_ack_done_o,
    output logic        error_o,
    output logic [1:0]  error_type_o,
    output logic [15:0] error_target_id_o
);

    // Target of the running command, reported with any error
    always_ff @(posedge log_clk) begin
        if (cmd_start_i) begin
            error_target_id_o <= des_id_i;
        end
    end

    always_ff @(posedge log_clk) begin
        if (log_rst) begin
            nwr_ready_o <= 1'b0;
            nwr_busy_o <= 1'b0;
            nwr_ack_done_o <= 1'b0;
            error_o <= 1'b0;
            error_type_o <= srio_pkg::ERR_NONE;
        end else begin
            nwr_ack_done_o <= ack_done_i;
            if (cmd_start_i) begin
                nwr_busy_o <= 1'b0;
                error_o <= 1'b0;
                error_type_o <= srio_pkg::ERR_NONE;
            end
            // A busy target is no longer ready
            if (nwr_start_i || got_busy_i) begin
                nwr_ready_o <= 1'b0;
            end else if (got_ready_i) begin
                nwr_ready_o <= 1'b1;
            end
            if (got_busy_i) begin
                nwr_busy_o <= 1'b1;
            end
            if (db_timeout_i) begin
                error_o <= 1'b1;
                error_type_o <= srio_pkg::ERR_DB_TIMEOUT;
            end else if (ack_timeout_i) begin
                error_o <= 1'b1;
                error_type_o <= srio_pkg::ERR_ACK_TIMEOUT;
            end
        end
    end

endmodule

// ==== rtl/srio_db_requester.sv ====
// RapidIO write source; one NWRITE per command, user packet must fit in the 512-beat FIFO
module srio_db_requester (
    input  logic                         log_clk,
    input  logic                         log_rst,
    input  logic [15:0]                  src_id_i,
    input  logic [15:0]                  des_id_i,
    input  logic                         self_check_i,
    input  logic                         nwr_req_i,
    input  logic                         link_initialized_i,
    output logic                         rapidio_ready_o,
    output logic                         nwr_ready_o,
    output logic                         nwr_busy_o,
    output logic                         nwr_ack_done_o,
    output logic                         error_o,
    output logic [1:0]                   error_type_o,
    output logic [15:0]                  error_target_id_o,
    input  logic                         user_tvalid_i,
    input  logic                         user_tfirst_i,
    input  logic [7:0]                   user_tsize_i,
    input  logic [srio_pkg::DATA_W-1:0]  user_tdata_i,
    input  logic [srio_pkg::KEEP_W-1:0]  user_tkeep_i,
    input  logic                         user_tlast_i,
    output logic                         user_tready_o,
    output logic                         ireq_tvalid_o,
    input  logic                         ireq_tready_i,
    output logic [srio_pkg::DATA_W-1:0]  ireq_tdata_o,
    output logic [srio_pkg::KEEP_W-1:0]  ireq_tkeep_o,
    output logic                         ireq_tlast_o,
    output logic [31:0]                  ireq_tuser_o,
    input  logic                         iresp_tvalid_i,
    output logic                         iresp_tready_o,
    input  logic [srio_pkg::DATA_W-1:0]  iresp_tdata_i,
    input  logic [31:0]                  iresp_tuser_i
);

    logic                        fifo_full;
    logic                        fifo_pop;
    logic                        head_valid;
    logic                        head_first;
    logic                        head_last;
    logic [srio_pkg::KEEP_W-1:0] head_keep;
    logic [srio_pkg::DATA_W-1:0] head_data;
    logic [srio_pkg::DATA_W-1:0] push_data;
    logic [15:0]                 expect_info;
    logic ev_ready, ev_busy, ev_confirm;
    logic cmd_start, nwr_start, got_ready, got_busy;
    logic db_timeout, ack_timeout, ack_done;

    assign user_tready_o = !fifo_full;
    assign iresp_tready_o = 1'b1;
    // Header beats store only the size byte
    assign push_data = user_tfirst_i ? srio_pkg::DATA_W'(user_tsize_i) : user_tdata_i;

    user_beat_fifo user_beat_fifo_i (
        .log_clk      (log_clk),
        .log_rst      (log_rst),
        .push_i       (user_tvalid_i),
        .push_first_i (user_tfirst_i),
        .push_last_i  (user_tlast_i),
        .push_keep_i  (user_tkeep_i),
        .push_data_i  (push_data),
        .pop_i        (fifo_pop),
        .full_o       (fifo_full),
        .head_valid_o (head_valid),
        .head_first_o (head_first),
        .head_last_o  (head_last),
        .head_keep_o  (head_keep),
        .head_data_o  (head_data)
    );

    resp_decode resp_decode_i (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .expect_info_i  (expect_info),
        .ev_ready_o     (ev_ready),
        .ev_busy_o      (ev_busy),
        .ev_confirm_o   (ev_confirm)
    );

    req_sequencer req_sequencer_i (
        .log_clk            (log_clk),
        .log_rst            (log_rst),
        .self_check_i       (self_check_i),
        .nwr_req_i          (nwr_req_i),
        .link_initialized_i (link_initialized_i),
        .src_id_i           (src_id_i),
        .des_id_i           (des_id_i),
        .ireq_tready_i      (ireq_tready_i),
        .head_valid_i       (head_valid),
        .head_first_i       (head_first),
        .head_last_i        (head_last),
        .head_keep_i        (head_keep),
        .head_data_i        (head_data),
        .ev_ready_i         (ev_ready),
        .ev_busy_i          (ev_busy),
        .ev_confirm_i       (ev_confirm),
        .ireq_tvalid_o      (ireq_tvalid_o),
        .ireq_tdata_o       (ireq_tdata_o),
        .ireq_tkeep_o       (ireq_tkeep_o),
        .ireq_tlast_o       (ireq_tlast_o),
        .ireq_tuser_o       (ireq_tuser_o),
        .fifo_pop_o         (fifo_pop),
        .expect_info_o      (expect_info),
        .rapidio_ready_o    (rapidio_ready_o),
        .cmd_start_o        (cmd_start),
        .nwr_start_o        (nwr_start),
        .got_ready_o        (got_ready),
        .got_busy_o         (got_busy),
        .db_timeout_o       (db_timeout),
        .ack_timeout_o      (ack_timeout),
        .ack_done_o         (ack_done)
    );

    status_report status_report_i (
        .log_clk           (log_clk),
        .log_rst           (log_rst),
        .des_id_i          (des_id_i),
        .cmd_start_i       (cmd_start),
        .nwr_start_i       (nwr_start),
        .got_ready_i       (got_ready),
        .got_busy_i        (got_busy),
        .db_timeout_i      (db_timeout),
        .ack_timeout_i     (ack_timeout),
        .ack_done_i        (ack_done),
        .nwr_ready_o       (nwr_ready_o),
        .nwr_busy_o        (nwr_busy_o),
        .nwr_ack_done_o    (nwr_ack_done_o),
        .error_o           (error_o),
        .error_type_o      (error_type_o),
        .error_target_id_o (error_target_id_o)
    );

endmodule

// ==== verification/tb_srio_db_requester.sv ====
// Directed testbench with a simple target model; the timeout tests need about 140k cycles
module tb_srio_db_requester;

    localparam int WAIT_LIMIT = srio_pkg::TIMEOUT_CYCLES + 1024;
    localparam logic [15:0] SRC_ID = 16'h0012;

    logic        log_clk = 1'b0;
    logic        log_rst = 1'b1;
    logic [15:0] src_id, des_id;
    logic        self_check, nwr_req, link_init;
    logic        rapidio_ready, nwr_ready, nwr_busy, nwr_ack_done, error_flag;
    logic [1:0]  error_type;
    logic [15:0] error_target_id;
    logic        user_tvalid, user_tfirst, user_tlast, user_tready;
    logic [7:0]  user_tsize, user_tkeep;
    logic [63:0] user_tdata;
    logic        ireq_tvalid, ireq_tlast;
    logic        ireq_tready = 1'b1;
    logic [63:0] ireq_tdata;
    logic [7:0]  ireq_tkeep;
    logic [31:0] ireq_tuser;
    logic        iresp_tvalid, iresp_tready;
    logic [63:0] iresp_tdata;
    logic [31:0] iresp_tuser;

    // Expected request beats in send order
    logic [63:0] exp_data [32];
    logic [7:0]  exp_keep [32];
    logic        exp_last [32];
    int          exp_count = 0;
    int          exp_rd = 0;

    logic        status_chk = 1'b0;
    logic        exp_ready, exp_busy, exp_error;
    logic [1:0]  exp_err_type;
    logic [15:0] exp_target;
    logic        bp_enable = 1'b0;
    logic [31:0] rnd_state = 32'd27400;
    int          ack_pulses = 0;
    int          errors = 0;
    int          timeouts = 0;

    always #4 log_clk = ~log_clk;

    srio_db_requester srio_db_requester_i (
        .log_clk            (log_clk),
        .log_rst            (log_rst),
        .src_id_i           (src_id),
        .des_id_i           (des_id),
        .self_check_i       (self_check),
        .nwr_req_i          (nwr_req),
        .link_initialized_i (link_init),
        .rapidio_ready_o    (rapidio_ready),
        .nwr_ready_o        (nwr_ready),
        .nwr_busy_o         (nwr_busy),
        .nwr_ack_done_o     (nwr_ack_done),
        .error_o            (error_flag),
        .error_type_o       (error_type),
        .error_target_id_o  (error_target_id),
        .user_tvalid_i      (user_tvalid),
        .user_tfirst_i      (user_tfirst),
        .user_tsize_i       (user_tsize),
        .user_tdata_i       (user_tdata),
        .user_tkeep_i       (user_tkeep),
        .user_tlast_i       (user_tlast),
        .user_tready_o      (user_tready),
        .ireq_tvalid_o      (ireq_tvalid),
        .ireq_tready_i      (ireq_tready),
        .ireq_tdata_o       (ireq_tdata),
        .ireq_tkeep_o       (ireq_tkeep),
        .ireq_tlast_o       (ireq_tlast),
        .ireq_tuser_o       (ireq_tuser),
        .iresp_tvalid_i     (iresp_tvalid),
        .iresp_tready_o     (iresp_tready),
        .iresp_tdata_i      (iresp_tdata),
        .iresp_tuser_i      (iresp_tuser)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Link side back-pressure keeps ready high about three cycles in four
    always @(negedge log_clk) begin
        if (bp_enable) begin
            rnd_state = xorshift32(rnd_state);
            ireq_tready <= rnd_state[0] | rnd_state[1];
        end else begin
            ireq_tready <= 1'b1;
        end
    end

    always @(posedge log_clk) begin
        if (!log_rst && ireq_tvalid && ireq_tready) begin
            exp_rd <= exp_rd + 1;
        end
        if (!log_rst && nwr_ack_done) begin
            ack_pulses <= ack_pulses + 1;
        end
    end

    assert property (@(posedge log_clk) $fell(log_rst) |->
        !ireq_tvalid && rapidio_ready && !nwr_ready && !nwr_busy && !error_flag
        && !nwr_ack_done && error_type == srio_pkg::ERR_NONE)
    else begin
        errors++;
        $display("FAILED %0t: outputs are not in their reset state", $time);
    end

    assert property (@(posedge log_clk) disable iff (log_rst)
        (ireq_tvalid && ireq_tready) |-> (exp_rd < exp_count)
        && ireq_tdata == exp_data[exp_rd] && ireq_tkeep == exp_keep[exp_rd]
        && ireq_tlast == exp_last[exp_rd])
    else begin
        errors++;
        $display("FAILED %0t: request beat %0d is data %h keep %h last %b",
                 $time, exp_rd, ireq_tdata, ireq_tkeep, ireq_tlast);
    end

    assert property (@(posedge log_clk) disable iff (log_rst)
        (ireq_tvalid && !ireq_tready) |=> ireq_tvalid && $stable(ireq_tdata)
        && $stable(ireq_tkeep) && $stable(ireq_tlast))
    else begin
        errors++;
        $display("FAILED %0t: request beat changed while stalled", $time);
    end

    assert property (@(posedge log_clk) disable iff (log_rst)
        ireq_tvalid |-> ireq_tuser == {src_id, des_id})
    else begin
        errors++;
        $display("FAILED %0t: request tuser is %h", $time, ireq_tuser);
    end

    assert property (@(posedge log_clk) disable iff (log_rst) iresp_tready)
    else begin
        errors++;
        $display("FAILED %0t: response ready is low", $time);
    end

    // Packets here are far smaller than the FIFO, so it never fills
    assert property (@(posedge log_clk) disable iff (log_rst) user_tready)
    else begin
        errors++;
        $display("FAILED %0t: user ready is low with a nearly empty FIFO", $time);
    end

    assert property (@(posedge log_clk) disable iff (log_rst)
        status_chk |-> nwr_ready == exp_ready && nwr_busy == exp_busy
        && error_flag == exp_error && error_type == exp_err_type
        && (!exp_error || error_target_id == exp_target))
    else begin
        errors++;
        $display("FAILED %0t: status ready %b busy %b error %b type %0d target %h",
                 $time, nwr_ready, nwr_busy, error_flag, error_type, error_target_id);
    end

    assert property (@(posedge log_clk) disable iff (log_rst)
        nwr_ack_done |=> !nwr_ack_done)
    else begin
        errors++;
        $display("FAILED %0t: confirmation pulse longer than one cycle", $time);
    end

    task automatic finish_report();
        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at time %0t", what, $time);
        timeouts++;
    endtask

    task automatic wait_beats_sent();
        int cycles;
        cycles = 0;
        while (exp_rd != exp_count) begin
            @(negedge log_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("the expected request beats");
                break;
            end
        end
    endtask

    // Returns one cycle after IDLE so the status registers have settled
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!rapidio_ready) begin
            @(negedge log_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("the requester to return to idle");
                break;
            end
        end
        @(negedge log_clk);
    endtask

    task automatic expect_beat(input logic [63:0] data, input logic [7:0] keep,
                               input logic last);
        exp_data[exp_count] = data;
        exp_keep[exp_count] = keep;
        exp_last[exp_count] = last;
        exp_count++;
    endtask

    task automatic push_user_beat(input logic first, input logic [7:0] size,
                                  input logic [63:0] data, input logic [7:0] keep,
                                  input logic last);
        int cycles;
        cycles = 0;
        while (!user_tready) begin
            @(negedge log_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("user ready");
                break;
            end
        end
        user_tvalid = 1'b1;
        user_tfirst = first;
        user_tsize = size;
        user_tdata = data;
        user_tkeep = keep;
        user_tlast = last;
        @(negedge log_clk);
        user_tvalid = 1'b0;
    endtask

    // Buffers one packet and records the beats the link should see for it
    task automatic queue_nwrite(input logic [7:0] tid, input logic [7:0] size, input int beats,
                                input logic [srio_pkg::ADDR_W-1:0] addr,
                                input logic [15:0] info);
        logic [63:0] data;
        logic [7:0]  keep;
        expect_beat(srio_pkg::build_nwr_header(tid, size, addr), 8'hFF, 1'b0);
        rnd_state = xorshift32(rnd_state);
        push_user_beat(1'b1, size, {rnd_state, ~rnd_state}, 8'hFF, 1'b0);
        for (int i = 0; i < beats; i++) begin
            rnd_state = xorshift32(rnd_state);
            data[63:32] = rnd_state;
            rnd_state = xorshift32(rnd_state);
            data[31:0] = rnd_state;
            keep = rnd_state[7:0] | 8'h01;
            expect_beat(data, keep, i == beats - 1);
            push_user_beat(1'b0, 8'd0, data, keep, i == beats - 1);
        end
        expect_beat(srio_pkg::build_doorbell(tid, info), 8'hFF, 1'b1);
    endtask

    task automatic start_command(input logic is_self);
        self_check = is_self;
        nwr_req = !is_self;
        @(negedge log_clk);
        self_check = 1'b0;
        nwr_req = 1'b0;
    endtask

    task automatic send_reply(input logic [15:0] info);
        iresp_tvalid = 1'b1;
        iresp_tdata = srio_pkg::build_doorbell(8'd0, info);
        iresp_tuser = {srio_pkg::TARGET_RESP_ID, SRC_ID};
        @(negedge log_clk);
        iresp_tvalid = 1'b0;
    endtask

    task automatic check_status(input logic ready, input logic busy, input logic err,
                                input logic [1:0] err_type, input logic [15:0] target);
        exp_ready = ready;
        exp_busy = busy;
        exp_error = err;
        exp_err_type = err_type;
        exp_target = target;
        status_chk = 1'b1;
        @(negedge log_clk);
        status_chk = 1'b0;
    endtask

    initial begin
        logic [srio_pkg::ADDR_W-1:0] win1_addr;
        src_id = SRC_ID;
        des_id = 16'h0034;
        self_check = 1'b0;
        nwr_req = 1'b0;
        link_init = 1'b0;
        user_tvalid = 1'b0;
        user_tfirst = 1'b0;
        user_tsize = 8'd0;
        user_tdata = '0;
        user_tkeep = '0;
        user_tlast = 1'b0;
        iresp_tvalid = 1'b0;
        iresp_tdata = '0;
        iresp_tuser = '0;
        win1_addr = '0;
        win1_addr[srio_pkg::WINDOW_STRIDE_SHIFT] = 1'b1;
        repeat (16) @(posedge log_clk);
        @(negedge log_clk);
        log_rst = 1'b0;
        link_init = 1'b1;
        @(negedge log_clk);

        // Self-check answered ready
        expect_beat(srio_pkg::build_doorbell(8'd0, srio_pkg::DB_INFO_SELF), 8'hFF, 1'b1);
        start_command(1'b1);
        wait_beats_sent();
        send_reply(srio_pkg::DB_INFO_READY);
        wait_idle();
        check_status(1'b1, 1'b0, 1'b0, srio_pkg::ERR_NONE, des_id);

        // Self-check answered busy
        expect_beat(srio_pkg::build_doorbell(8'd0, srio_pkg::DB_INFO_SELF), 8'hFF, 1'b1);
        start_command(1'b1);
        wait_beats_sent();
        send_reply(srio_pkg::DB_INFO_BUSY);
        wait_idle();
        check_status(1'b0, 1'b1, 1'b0, srio_pkg::ERR_NONE, des_id);

        // Silent target so the error names the destination captured at start
        des_id = 16'h0077;
        expect_beat(srio_pkg::build_doorbell(8'd0, srio_pkg::DB_INFO_SELF), 8'hFF, 1'b1);
        start_command(1'b1);
        wait_beats_sent();
        des_id = 16'h0099;
        wait_idle();
        check_status(1'b0, 1'b0, 1'b1, srio_pkg::ERR_DB_TIMEOUT, 16'h0077);

        // First write in window 0 gets confirmed
        queue_nwrite(8'd0, 8'd31, 4, '0, 16'h0201);
        bp_enable = 1'b1;
        start_command(1'b0);
        wait_beats_sent();
        bp_enable = 1'b0;
        send_reply(16'h0201);
        wait_idle();
        check_status(1'b0, 1'b0, 1'b0, srio_pkg::ERR_NONE, des_id);
        assert (ack_pulses == 1)
        else begin
            errors++;
            $display("FAILED %0t: expected one confirmation pulse, saw %0d", $time, ack_pulses);
        end

        // Second write in window 1 is never confirmed
        queue_nwrite(8'd1, 8'd23, 3, win1_addr, 16'h0200);
        bp_enable = 1'b1;
        start_command(1'b0);
        wait_beats_sent();
        bp_enable = 1'b0;
        wait_idle();
        check_status(1'b0, 1'b0, 1'b1, srio_pkg::ERR_ACK_TIMEOUT, des_id);

        repeat (4) @(negedge log_clk);
        finish_report();
    end

endmodule

// ==== srio_db_requester.f ====
rtl/srio_pkg.sv
rtl/user_beat_fifo.sv
rtl/resp_decode.sv
rtl/req_sequencer.sv
rtl/status_report.sv
rtl/srio_db_requester.sv
verification/tb_srio_db_requester.sv

// ==== Makefile ====
TOP = tb_srio_db_requester

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f srio_db_requester.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f srio_db_requester.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
